//--- busPkg.sv
// ===================================================================
// Wishbone classic bus types and the register map of the converter
// ===================================================================
package busPkg;

	// Bus widths, word addressed
	localparam int WbAdrW = 2;
	localparam int WbDatW = 32;

	// Register word addresses
	localparam logic [WbAdrW-1:0] RegCtrl   = 2'd0;
	localparam logic [WbAdrW-1:0] RegStatus = 2'd1;

	// Control register fields, chip sits in the two low bits
	localparam int CtrlCol80Bit  = 2;
	localparam int CtrlEnableBit = 3;

	// Status register places the last frame's line count here
	localparam int StatLastLsb = 16;

	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [WbAdrW-1:0] adr;
		logic [WbDatW-1:0] dat;
	} wbReq_t;

	typedef struct packed {
		logic ack;
		logic [WbDatW-1:0] dat;
	} wbRsp_t;

endpackage

//--- frameStore.sv
// ===================================================================
// One write and one registered read port, read-before-write on a clash.
// Needs about 162 kB of block RAM
// ===================================================================
module frameStore (
	input  logic                                clk33,
	input  videoPkg::bufWrite_t                 wr_i,
	input  logic [videoPkg::BufAddrW-1:0]       rdAddr_i,
	output logic [videoPkg::ColorW-1:0]         rdColor_o
);

	(* ram_style = "block" *)
	logic [videoPkg::ColorW-1:0] mem [0:videoPkg::BufDepth-1];

	logic inRange;

	// Writes past the last word would alias nothing useful, so drop them
	assign inRange = wr_i.addr < videoPkg::BufAddrW'(videoPkg::BufDepth);

	always_ff @(posedge clk33) begin
		if (wr_i.we && inRange)
			mem[wr_i.addr] <= wr_i.color;
	end

	// Synchronous read, a write shows up here from the next clock on
	always_ff @(posedge clk33) begin
		rdColor_o <= mem[rdAddr_i];
	end

endmodule

//--- outputRaster.sv
// ===================================================================
// Output side advances on pixEn_i only. colorOut follows the counted
// position by exactly two pixEn_i cycles whatever their spacing
// ===================================================================
module outputRaster (
	input  logic                                clk33,
	input  logic                                rst_i,
	input  logic                                pixEn_i,
	input  logic                                hSync_i,
	input  logic                                vSync_i,
	input  videoPkg::scanCfg_t                  cfg_i,
	input  logic [videoPkg::ColorW-1:0]         rdColor_i,
	output logic [videoPkg::BufAddrW-1:0]       rdAddr_o,
	output logic [videoPkg::ColorW-1:0]         color_o
);

	logic phSync;
	logic pvSync;
	logic hFall;
	logic vFall;
	logic [videoPkg::OutXW-1:0] xCnt;
	logic [videoPkg::OutYW-1:0] yCnt;
	logic [videoPkg::OutXW-1:0] xNext;
	logic [videoPkg::OutYW-1:0] yNext;
	logic [videoPkg::SrcYW+videoPkg::SrcXW-1:0] rowBase;
	logic [videoPkg::SrcYW+videoPkg::SrcXW-1:0] fullAddr;
	logic [videoPkg::ColorW-1:0] colorMid;

	// Falling edges, only looked at on output pixel cycles
	assign hFall = pixEn_i & ~hSync_i & phSync;
	assign vFall = pixEn_i & ~vSync_i & pvSync;

	// Next position equals the current one between pixel enables
	assign xNext = !pixEn_i ? xCnt : (hFall ? '0 : xCnt + 12'd1);
	assign yNext = vFall ? '0 : (hFall ? yCnt + 10'd1 : yCnt);

	// Halving both coordinates doubles every source dot and line
	assign rowBase = yNext[videoPkg::OutYW-1:1] * cfg_i.lineStride;
	assign fullAddr = rowBase + {{videoPkg::SrcYW{1'b0}}, xNext[videoPkg::OutXW-1:1]};
	// Address of the next position, so the RAM output is settled by the next enable
	assign rdAddr_o = fullAddr[videoPkg::BufAddrW-1:0];

	// ===================================================================
	// Counters and colour pipeline
	// ===================================================================
	always_ff @(posedge clk33) begin
		if (rst_i) begin
			phSync <= 1'b0;
			pvSync <= 1'b0;
			xCnt <= '0;
			yCnt <= '0;
			colorMid <= '0;
			color_o <= '0;
		end else begin
			xCnt <= xNext;
			yCnt <= yNext;
			if (pixEn_i) begin
				phSync <= hSync_i;
				pvSync <= vSync_i;
				// Two enable-qualified stages give the fixed latency
				colorMid <= rdColor_i;
				color_o <= colorMid;
			end
		end
	end

endmodule

//--- scanConverter.sv
// ===================================================================
// Scan converter top, single clock. The output pixel enable and syncs
// come from an external display timing generator
// ===================================================================
module scanConverter (
	input  logic                            clk33,
	input  logic                            rst_i,
	// Source raster from the video chip
	input  logic                            dotEn_i,
	input  logic                            hSyncIn_i,
	input  logic                            vSyncIn_i,
	input  logic [videoPkg::ColorW-1:0]     colorIn_i,
	// Display raster
	input  logic                            pixEn_i,
	input  logic                            hSyncOut_i,
	input  logic                            vSyncOut_i,
	output logic [videoPkg::ColorW-1:0]     colorOut_o,
	// Configuration bus
	input  busPkg::wbReq_t                  wbReq_i,
	output busPkg::wbRsp_t                  wbRsp_o
);

	videoPkg::scanCfg_t cfg;
	videoPkg::srcStatus_t status;
	videoPkg::bufWrite_t wr;
	logic [videoPkg::BufAddrW-1:0] rdAddr;
	logic [videoPkg::ColorW-1:0] rdColor;

	// Register block feeds both rasters with the same stride
	scanRegs uRegs (
		.clk33    (clk33),
		.rst_i    (rst_i),
		.wbReq_i  (wbReq_i),
		.status_i (status),
		.wbRsp_o  (wbRsp_o),
		.cfg_o    (cfg)
	);

	sourceRaster uSrc (
		.clk33    (clk33),
		.rst_i    (rst_i),
		.dotEn_i  (dotEn_i),
		.hSync_i  (hSyncIn_i),
		.vSync_i  (vSyncIn_i),
		.color_i  (colorIn_i),
		.cfg_i    (cfg),
		.wr_o     (wr),
		.status_o (status)
	);

	frameStore uStore (
		.clk33     (clk33),
		.wr_i      (wr),
		.rdAddr_i  (rdAddr),
		.rdColor_o (rdColor)
	);

	outputRaster uOut (
		.clk33     (clk33),
		.rst_i     (rst_i),
		.pixEn_i   (pixEn_i),
		.hSync_i   (hSyncOut_i),
		.vSync_i   (vSyncOut_i),
		.cfg_i     (cfg),
		.rdColor_i (rdColor),
		.rdAddr_o  (rdAddr),
		.color_o   (colorOut_o)
	);

endmodule

//--- scanConverter_asserts.sv
// ======================================================================
// Bus and write path checks, bound into the register block and source
// raster. A block without one of the signals has that port tied low
// ======================================================================
module scanConverter_asserts (
	input logic clk33,
	input logic rst_i,
	input logic cyc_i,
	input logic stb_i,
	input logic ack_i,
	input logic we_i,
	input logic enable_i
);

	// Failed assertions so far, the testbench reads this count back
	int failCnt = 0;

	// One acknowledge per strobe, the slave waits for stb to drop
	ackOnce: assert property (@(posedge clk33) disable iff (rst_i)
		(ack_i && stb_i) |=> !(ack_i && stb_i))
		else begin
			failCnt++;
			$error("ack stayed high for two cycles under one strobe");
		end

	// An acknowledge always answers a cycle that was open
	ackNeedsCyc: assert property (@(posedge clk33) disable iff (rst_i)
		$rose(ack_i) |-> $past(cyc_i))
		else begin
			failCnt++;
			$error("ack rose without cyc");
		end

	// Write enable is registered, so it follows the enable of the previous clock
	writeEnabled: assert property (@(posedge clk33) disable iff (rst_i)
		we_i |-> $past(enable_i))
		else begin
			failCnt++;
			$error("buffer write while the converter was disabled");
		end

endmodule

bind scanRegs scanConverter_asserts uRegChecks (
	.clk33    (clk33),
	.rst_i    (rst_i),
	.cyc_i    (wbReq_i.cyc),
	.stb_i    (wbReq_i.stb),
	.ack_i    (wbRsp_o.ack),
	.we_i     (1'b0),
	.enable_i (cfg_o.enable)
);

bind sourceRaster scanConverter_asserts uSrcChecks (
	.clk33    (clk33),
	.rst_i    (rst_i),
	.cyc_i    (1'b0),
	.stb_i    (1'b0),
	.ack_i    (1'b0),
	.we_i     (wr_o.we),
	.enable_i (cfg_i.enable)
);

//--- scanConverter_tb.sv
// ======================================================================
// Small frames of a few lines only, every pixel enable has 0 to 2 idle
// clocks in front of it. Runs on a single 10 unit clock
// ======================================================================
module scanConverter_tb;

	// Frame shape and worst case cost of one enable with its gap
	localparam int Lines = 3;
	localparam int Width = 6;
	localparam int MaxStep = 3;
	localparam int SrcFrameCyc = Lines * Width * MaxStep + 3;
	localparam int OutFrameCyc = (2 * Lines * (2 * Width + 1) + 2) * MaxStep + 1;
	localparam int StatusCyc = (3 + 5 + 2) * Width * MaxStep + 3 * 3;
	localparam int BusCyc = 40 * 5;
	localparam int TestCyc = 4 + 9 * (SrcFrameCyc + OutFrameCyc) + StatusCyc + BusCyc;
	localparam int CycleLimit = TestCyc + TestCyc / 4;

	logic clk33 = 1'b0;
	logic rst_i;
	logic dotEn_i;
	logic hSyncIn_i;
	logic vSyncIn_i;
	logic [videoPkg::ColorW-1:0] colorIn_i;
	logic pixEn_i;
	logic hSyncOut_i;
	logic vSyncOut_i;
	logic [videoPkg::ColorW-1:0] colorOut_o;
	busPkg::wbReq_t wbReq_i;
	busPkg::wbRsp_t wbRsp_o;

	// Model state of both rasters and of the buffer contents
	logic [videoPkg::ColorW-1:0] shadow [int];
	logic modelEn = 1'b0;
	logic [videoPkg::SrcXW-1:0] modelStride = 11'd528;
	logic srcPrevH = 1'b0;
	logic srcPrevV = 1'b0;
	logic [videoPkg::SrcXW-1:0] srcX = '0;
	logic [videoPkg::SrcYW-1:0] srcY = '0;
	logic outPrevH = 1'b0;
	logic outPrevV = 1'b0;
	logic [videoPkg::OutXW-1:0] outX = '0;
	logic [videoPkg::OutYW-1:0] outY = '0;
	// Expected colours in pixel enable order, -1 marks a sync cycle
	int expQ [$];
	int expEntry;
	logic [videoPkg::ColorW-1:0] expColor;
	int cycleCnt = 0;

	scanConverter u_dut (
		.clk33      (clk33),
		.rst_i      (rst_i),
		.dotEn_i    (dotEn_i),
		.hSyncIn_i  (hSyncIn_i),
		.vSyncIn_i  (vSyncIn_i),
		.colorIn_i  (colorIn_i),
		.pixEn_i    (pixEn_i),
		.hSyncOut_i (hSyncOut_i),
		.vSyncOut_i (vSyncOut_i),
		.colorOut_o (colorOut_o),
		.wbReq_i    (wbReq_i),
		.wbRsp_o    (wbRsp_o)
	);

	always #5 clk33 = ~clk33;

	// ======================================================================
	// Reference model, reporting and compare tasks
	// ======================================================================
	// Dots per source line, 80-column lines are twice as long
	function automatic logic [videoPkg::SrcXW-1:0] refStride(input logic [1:0] chip,
			input logic col80);
		logic [videoPkg::SrcXW-1:0] base;
		case (chip)
			videoPkg::ChipR8: base = 11'd528;
			videoPkg::ChipOld: base = 11'd520;
			default: base = 11'd512;
		endcase
		return col80 ? base << 1 : base;
	endfunction

	task automatic failRun(input string why);
		$display("%s", why);
		$display("Finished with errors");
		$fatal(1, "simulation stopped");
	endtask

	// Failures counted by both bound checker instances
	function automatic int assertFails();
		return u_dut.uRegs.uRegChecks.failCnt + u_dut.uSrc.uSrcChecks.failCnt;
	endfunction

	task automatic checkColor(input logic [videoPkg::ColorW-1:0] got,
			input logic [videoPkg::ColorW-1:0] exp, input string what);
		if (got !== exp)
			failRun($sformatf("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp));
	endtask

	task automatic checkWord(input logic [busPkg::WbDatW-1:0] got,
			input logic [busPkg::WbDatW-1:0] exp, input string what);
		if (got !== exp)
			failRun($sformatf("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp));
	endtask

	// ======================================================================
	// Bus, source and display stimulus
	// ======================================================================
	task automatic busAccess(input logic we, input logic [busPkg::WbAdrW-1:0] adr,
			input logic [busPkg::WbDatW-1:0] wdat, output logic [busPkg::WbDatW-1:0] rdat);
		int waitCnt;
		int holdCnt;
		@(negedge clk33);
		wbReq_i = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
		waitCnt = 0;
		do begin
			@(negedge clk33);
			waitCnt++;
		end while (!wbRsp_o.ack && waitCnt < 4);
		if (!wbRsp_o.ack)
			failRun("Wishbone access was never acknowledged");
		checkWord(waitCnt, 1, "ack latency in clocks");
		rdat = wbRsp_o.dat;
		// The master may keep the strobe up for a while after the ack
		holdCnt = $urandom_range(0, 2);
		repeat (holdCnt) begin
			@(negedge clk33);
			checkWord({31'd0, wbRsp_o.ack}, '0, "ack under a held strobe");
		end
		wbReq_i = '0;
	endtask

	// Control writes also move the model's enable and stride
	task automatic writeCtrl(input logic [busPkg::WbDatW-1:0] val);
		logic [busPkg::WbDatW-1:0] unused;
		busAccess(1'b1, busPkg::RegCtrl, val, unused);
		modelEn = val[busPkg::CtrlEnableBit];
		modelStride = refStride(val[1:0], val[busPkg::CtrlCol80Bit]);
	endtask

	task automatic srcDot(input logic h, input logic v, input logic [videoPkg::ColorW-1:0] c);
		logic hRise;
		logic vRise;
		repeat ($urandom_range(0, 2)) begin
			@(negedge clk33);
			dotEn_i = 1'b0;
		end
		@(negedge clk33);
		dotEn_i = 1'b1;
		hSyncIn_i = h;
		vSyncIn_i = v;
		colorIn_i = c;
		// Rising sync edges against the level of the previous dot
		hRise = h & ~srcPrevH;
		vRise = v & ~srcPrevV;
		srcX = hRise ? '0 : srcX + 1'b1;
		srcY = vRise ? '0 : (hRise ? srcY + 1'b1 : srcY);
		srcPrevH = h;
		srcPrevV = v;
		if (modelEn)
			shadow[int'(srcY) * int'(modelStride) + int'(srcX)] = c;
	endtask

	// hSync marks the first dot of each line, vSync also the first line
	task automatic sendFrame(input int lines, input int width);
		logic [videoPkg::ColorW-1:0] c;
		for (int l = 0; l < lines; l++) begin
			for (int x = 0; x < width; x++) begin
				c = $urandom_range(0, (1 << videoPkg::ColorW) - 1);
				srcDot(x == 0, l == 0 && x == 0, c);
			end
		end
		@(negedge clk33);
		dotEn_i = 1'b0;
		repeat (2) @(negedge clk33);
	endtask

	task automatic outPix(input logic h, input logic v, input bit check);
		logic hFall;
		logic vFall;
		int addr;
		repeat ($urandom_range(0, 2)) begin
			@(negedge clk33);
			pixEn_i = 1'b0;
		end
		@(negedge clk33);
		pixEn_i = 1'b1;
		hSyncOut_i = h;
		vSyncOut_i = v;
		hFall = ~h & outPrevH;
		vFall = ~v & outPrevV;
		outX = hFall ? '0 : outX + 1'b1;
		outY = vFall ? '0 : (hFall ? outY + 1'b1 : outY);
		outPrevH = h;
		outPrevV = v;
		if (!check) begin
			expQ.push_back(-1);
		end else begin
			// Each source dot covers two output pixels on two output lines
			addr = int'(outY / 2) * int'(modelStride) + int'(outX / 2);
			if (!shadow.exists(addr))
				failRun($sformatf("Reference pixel at address %0d was never written", addr));
			expQ.push_back(int'(shadow[addr]));
		end
	endtask

	// A sync enable opens each output line, two more flush the pipeline
	task automatic runOutput(input int lines, input int width);
		expQ.delete();
		for (int l = 0; l < 2 * lines; l++) begin
			outPix(1'b1, l == 0, 1'b0);
			for (int x = 0; x < 2 * width; x++)
				outPix(1'b0, 1'b0, 1'b1);
		end
		repeat (2) outPix(1'b1, 1'b0, 1'b0);
		@(negedge clk33);
		pixEn_i = 1'b0;
		@(negedge clk33);
	endtask

	// Output colour is due two pixel enables after its position was counted
	always @(posedge clk33) begin
		if (pixEn_i && expQ.size() >= 3) begin
			expEntry = expQ.pop_front();
			@(negedge clk33);
			if (expEntry >= 0) begin
				expColor = expEntry[videoPkg::ColorW-1:0];
				checkColor(colorOut_o, expColor, "output colour");
			end
		end
	end

	always @(posedge clk33) begin
		cycleCnt++;
		if (cycleCnt > CycleLimit)
			failRun($sformatf("Timeout: tests still running after %0d cycles", cycleCnt));
		else if (assertFails() != 0)
			failRun("A bound assertion failed");
	end

	initial begin
		logic [busPkg::WbDatW-1:0] word;
		logic [busPkg::WbDatW-1:0] val;
		logic [busPkg::WbDatW-1:0] status;
		void'($urandom(32'hc52fd2f4));
		rst_i = 1'b1;
		dotEn_i = 1'b0;
		hSyncIn_i = 1'b0;
		vSyncIn_i = 1'b0;
		colorIn_i = '0;
		pixEn_i = 1'b0;
		hSyncOut_i = 1'b0;
		vSyncOut_i = 1'b0;
		wbReq_i = '0;
		repeat (4) @(posedge clk33);
		@(negedge clk33);
		rst_i = 1'b0;

		// Everything quiet and disabled out of reset
		checkColor(colorOut_o, '0, "colour after reset");
		checkWord({31'd0, wbRsp_o.ack}, '0, "ack after reset");

		// A strobe without cyc is no bus cycle, so nothing is acked or written
		@(negedge clk33);
		wbReq_i = '{cyc: 1'b0, stb: 1'b1, we: 1'b1, adr: busPkg::RegCtrl, dat: 32'hf};
		repeat (2) begin
			@(negedge clk33);
			checkWord({31'd0, wbRsp_o.ack}, '0, "ack without cyc");
		end
		wbReq_i = '0;

		busAccess(1'b0, busPkg::RegCtrl, '0, word);
		checkWord(word, '0, "RegCtrl after reset");

		// Only chip, col80 and enable are stored
		repeat (6) begin
			val = $urandom;
			writeCtrl(val);
			busAccess(1'b0, busPkg::RegCtrl, '0, word);
			checkWord(word, val & 32'hf, "RegCtrl readback");
		end
		writeCtrl('0);

		for (int col = 0; col < 2; col++) begin
			for (int chip = 0; chip < 4; chip++) begin
				writeCtrl(32'h8 | (col << 2) | chip);
				sendFrame(Lines, Width);
				runOutput(Lines, Width);
			end
		end

		// Line counts of known frames, the third frame is left open
		sendFrame(3, Width);
		sendFrame(5, Width);
		busAccess(1'b0, busPkg::RegStatus, '0, word);
		status = '0;
		status[8:0] = 9'd4;
		status[24:16] = 9'd3;
		checkWord(word, status, "RegStatus after frames of 3 and 5 lines");
		sendFrame(2, Width);
		busAccess(1'b0, busPkg::RegStatus, '0, word);
		status = '0;
		status[8:0] = 9'd1;
		status[24:16] = 9'd5;
		checkWord(word, status, "RegStatus during a partial frame");

		// Same geometry with enable clear, the display keeps the old frame
		writeCtrl(32'h7);
		sendFrame(Lines, Width);
		runOutput(Lines, Width);

		if (assertFails() != 0) begin
			failRun("A bound assertion failed");
		end else begin
			$display("Finished with no errors");
			$finish;
		end
	end

endmodule

//--- scanRegs.sv
// ===================================================================
// Wishbone classic slave, one wait state, no back-pressure. The stride
// is looked up when RegCtrl is written, so cfg_o follows on the ack
// ===================================================================
module scanRegs (
	input  logic                clk33,
	input  logic                rst_i,
	input  busPkg::wbReq_t      wbReq_i,
	input  videoPkg::srcStatus_t status_i,
	output busPkg::wbRsp_t      wbRsp_o,
	output videoPkg::scanCfg_t  cfg_o
);

	logic req;
	logic start;
	logic ack;
	logic acked;
	logic [1:0] chip;
	logic col80;
	logic enable;
	logic [videoPkg::SrcXW-1:0] stride;
	logic [busPkg::WbDatW-1:0] readWord;
	logic [busPkg::WbDatW-1:0] rdData;

	assign req = wbReq_i.cyc & wbReq_i.stb;
	// A new access only once the previous one has dropped stb
	assign start = req & ~ack & ~acked;

	// Read mux, reserved bits and unmapped words read as zero
	always_comb begin
		readWord = '0;
		case (wbReq_i.adr)
			busPkg::RegCtrl: begin
				readWord[1:0] = chip;
				readWord[busPkg::CtrlCol80Bit] = col80;
				readWord[busPkg::CtrlEnableBit] = enable;
			end
			busPkg::RegStatus: begin
				readWord[videoPkg::SrcYW-1:0] = status_i.curLine;
				readWord[busPkg::StatLastLsb +: videoPkg::SrcYW] = status_i.lastLines;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk33) begin
		if (rst_i) begin
			ack <= 1'b0;
			acked <= 1'b0;
			chip <= videoPkg::ChipR8;
			col80 <= 1'b0;
			enable <= 1'b0;
			stride <= videoPkg::StrideTab[0][videoPkg::ChipR8];
		end else begin
			ack <= start;
			// Remember the acked access until the master releases the strobe
			acked <= req & (acked | ack);
			if (start && wbReq_i.we && wbReq_i.adr == busPkg::RegCtrl) begin
				chip <= wbReq_i.dat[1:0];
				col80 <= wbReq_i.dat[busPkg::CtrlCol80Bit];
				enable <= wbReq_i.dat[busPkg::CtrlEnableBit];
				stride <= videoPkg::StrideTab[wbReq_i.dat[busPkg::CtrlCol80Bit]][wbReq_i.dat[1:0]];
			end
		end
	end

	// Read data lands together with ack
	always_ff @(posedge clk33) begin
		if (start)
			rdData <= readWord;
	end

	assign wbRsp_o = '{ack: ack, dat: rdData};
	assign cfg_o = '{enable: enable, lineStride: stride};

endmodule

//--- sourceRaster.sv
// ===================================================================
// Source side counters run only on dotEn_i. Addresses past the buffer
// end wrap at 19 bits and are dropped by the frame store
// ===================================================================
module sourceRaster (
	input  logic                              clk33,
	input  logic                              rst_i,
	input  logic                              dotEn_i,
	input  logic                              hSync_i,
	input  logic                              vSync_i,
	input  logic [videoPkg::ColorW-1:0]       color_i,
	input  videoPkg::scanCfg_t                cfg_i,
	output videoPkg::bufWrite_t               wr_o,
	output videoPkg::srcStatus_t              status_o
);

	logic phSync;
	logic pvSync;
	logic hRise;
	logic vRise;
	logic [videoPkg::SrcXW-1:0] xCnt;
	logic [videoPkg::SrcYW-1:0] yCnt;
	logic [videoPkg::SrcXW-1:0] xNext;
	logic [videoPkg::SrcYW-1:0] yNext;
	logic [videoPkg::SrcYW-1:0] lastLines;
	logic [videoPkg::SrcYW+videoPkg::SrcXW-1:0] lineBase;
	logic [videoPkg::SrcYW+videoPkg::SrcXW-1:0] pixAddr;
	logic wrEn;
	logic [videoPkg::BufAddrW-1:0] wrAddr;
	logic [videoPkg::ColorW-1:0] wrColor;

	// Sync edges are judged against the level seen on the previous dot
	assign hRise = hSync_i & ~phSync;
	assign vRise = vSync_i & ~pvSync;

	// Position after this dot's update, which is where the pixel belongs
	assign xNext = hRise ? '0 : xCnt + 11'd1;
	assign yNext = vRise ? '0 : (hRise ? yCnt + 9'd1 : yCnt);

	assign lineBase = yNext * cfg_i.lineStride;
	assign pixAddr = lineBase + {{videoPkg::SrcYW{1'b0}}, xNext};

	// ===================================================================
	// Counters and status
	// ===================================================================
	always_ff @(posedge clk33) begin
		if (rst_i) begin
			phSync <= 1'b0;
			pvSync <= 1'b0;
			xCnt <= '0;
			yCnt <= '0;
			lastLines <= '0;
			wrEn <= 1'b0;
		end else begin
			// Nothing is written while the converter is disabled
			wrEn <= dotEn_i & cfg_i.enable;
			if (dotEn_i) begin
				phSync <= hSync_i;
				pvSync <= vSync_i;
				xCnt <= xNext;
				yCnt <= yNext;
				// Lines of the frame just closed, line 0 included
				if (vRise)
					lastLines <= yCnt + 9'd1;
			end
		end
	end

	// Address and colour travel together into the buffer one clock later
	always_ff @(posedge clk33) begin
		if (dotEn_i) begin
			wrAddr <= pixAddr[videoPkg::BufAddrW-1:0];
			wrColor <= color_i;
		end
	end

	assign wr_o = '{we: wrEn, addr: wrAddr, color: wrColor};
	assign status_o = '{curLine: yCnt, lastLines: lastLines};

endmodule

//--- verilog.f
videoPkg.sv
busPkg.sv
scanRegs.sv
sourceRaster.sv
frameStore.sv
outputRaster.sv
scanConverter.sv
scanConverter_asserts.sv
scanConverter_tb.sv

//--- videoPkg.sv
// ===================================================================
// VIC-II family raster constants. Strides are dots per source line and
// the frame buffer holds one 4-bit colour per source dot
// ===================================================================
package videoPkg;

	// Chip family codes as held in the control register
	localparam logic [1:0] ChipR8   = 2'd0;
	localparam logic [1:0] ChipOld  = 2'd1;
	localparam logic [1:0] Chip6569 = 2'd2;
	localparam logic [1:0] Chip6572 = 2'd3;

	// Frame buffer geometry, sized for the longest 80-column frame
	localparam int BufAddrW = 19;
	localparam int unsigned BufDepth = 331776;
	localparam int ColorW = 4;

	// Source raster counters
	localparam int SrcXW = 11;
	localparam int SrcYW = 9;

	// The output raster runs at twice the source resolution in both axes
	localparam int OutXW = 12;
	localparam int OutYW = 10;

	// Line stride in dots, indexed first by col80 and then by chip
	localparam logic [SrcXW-1:0] StrideTab [2][4] = '{
		'{ChipR8: 11'd528, ChipOld: 11'd520, Chip6569: 11'd512, Chip6572: 11'd512},
		'{ChipR8: 11'd1056, ChipOld: 11'd1040, Chip6569: 11'd1024, Chip6572: 11'd1024}
	};

	// Live configuration seen by both raster counters
	typedef struct packed {
		logic enable;
		logic [SrcXW-1:0] lineStride;
	} scanCfg_t;

	// One frame buffer write
	typedef struct packed {
		logic we;
		logic [BufAddrW-1:0] addr;
		logic [ColorW-1:0] color;
	} bufWrite_t;

	// Source raster status reported through the register block
	typedef struct packed {
		logic [SrcYW-1:0] curLine;
		logic [SrcYW-1:0] lastLines;
	} srcStatus_t;

endpackage
